// File: rtl/hnmGeometryPkg.sv
`default_nettype none

package hnmGeometryPkg;

    localparam int rowBits = 4;                     // row index width
    localparam int colBits = 3;                     // column index width
    localparam int ssidBits = rowBits + colBits;    // full superstrip id

    localparam int nRows = 1 << rowBits;            // 16 memory rows
    localparam int nCols = 1 << colBits;            // 8 bits per row word

    localparam int ramReadLatency = 2;              // address reg plus data reg
    localparam int bypassDepth = ramReadLatency + 1; // recent writes kept for merging

    typedef logic [rowBits-1:0] rowIdxT;            // upper ssid bits
    typedef logic [colBits-1:0] colIdxT;            // lower ssid bits
    typedef logic [ssidBits-1:0] ssidT;             // {row, col}
    typedef logic [nCols-1:0] rowDataT;             // one hit bit per column

endpackage

`default_nettype wire

// File: rtl/hnmControlPkg.sv
`default_nettype none

package hnmControlPkg;

    // what a read in flight is for
    typedef enum logic [1:0] {
        reqNone,                                    // empty slot
        reqSetHit,                                  // read half of a read-modify-write
        reqQueryBit,                                // single ssid lookup
        reqQueryRow                                 // whole row lookup
    } reqKindE;

    typedef enum logic [1:0] {
        clearIdle,                                  // held here during reset
        clearSweep,                                 // zeroing one row per cycle
        clearSettle,                                // let the last writes land
        clearDone                                   // map usable
    } clearStateE;

    localparam int clearSettleCycles = 4;           // wait after last cleared row
    localparam int clearSettleBits = $clog2(clearSettleCycles);

    typedef logic [clearSettleBits-1:0] settleCountT;

endpackage

`default_nettype wire

// File: rtl/ssidMapRam.sv
`default_nettype none

module ssidMapRam (
    input  logic                    clk,
    input  logic                    writeEnable,
    input  hnmGeometryPkg::rowIdxT  writeRow,
    input  hnmGeometryPkg::rowDataT writeData,
    input  hnmGeometryPkg::rowIdxT  readRow,
    output hnmGeometryPkg::rowDataT readData
);

    hnmGeometryPkg::rowDataT mem [hnmGeometryPkg::nRows];       // the hit map itself
    hnmGeometryPkg::rowIdxT  readRowQ;                          // registered read address
    hnmGeometryPkg::rowDataT dataPipe [hnmGeometryPkg::ramReadLatency-1]; // output regs

    // write port
    always_ff @(posedge clk) begin
        if (writeEnable) begin
            mem[writeRow] <= writeData;                         // visible to next read sample
        end
    end

    // read port, address stage then data stages
    always_ff @(posedge clk) begin
        readRowQ <= readRow;
        dataPipe[0] <= mem[readRowQ];                           // old data on same-edge write
        for (int i = 1; i < hnmGeometryPkg::ramReadLatency - 1; i++) begin
            dataPipe[i] <= dataPipe[i-1];                       // extra latency if configured
        end
    end

    assign readData = dataPipe[hnmGeometryPkg::ramReadLatency-2];

endmodule

`default_nettype wire

// File: rtl/clearSequencer.sv
`default_nettype none

module clearSequencer (
    input  logic                   clk,
    input  logic                   reset,
    output logic                   ready,
    output logic                   clearWrite,
    output hnmGeometryPkg::rowIdxT clearRow
);

    hnmControlPkg::clearStateE   state;
    hnmGeometryPkg::rowIdxT      rowCount;      // row being zeroed
    hnmControlPkg::settleCountT  settleCount;   // cycles waited after sweep

    always_ff @(posedge clk) begin
        if (reset) begin
            state <= hnmControlPkg::clearIdle;  // restart the sweep once reset drops
            rowCount <= '0;
            settleCount <= '0;
        end else begin
            case (state)
                hnmControlPkg::clearIdle: begin
                    state <= hnmControlPkg::clearSweep;
                    rowCount <= '0;
                end
                hnmControlPkg::clearSweep: begin
                    rowCount <= rowCount + 1'b1;                // one row per cycle
                    if (rowCount == hnmGeometryPkg::rowIdxT'(hnmGeometryPkg::nRows - 1)) begin
                        state <= hnmControlPkg::clearSettle;    // last row issued
                        settleCount <= '0;
                    end
                end
                hnmControlPkg::clearSettle: begin
                    settleCount <= settleCount + 1'b1;
                    if (settleCount ==
                        hnmControlPkg::settleCountT'(hnmControlPkg::clearSettleCycles - 1)) begin
                        state <= hnmControlPkg::clearDone;
                    end
                end
                hnmControlPkg::clearDone: begin
                    state <= hnmControlPkg::clearDone;          // stay until next reset
                end
                default: begin
                    state <= hnmControlPkg::clearIdle;
                end
            endcase
        end
    end

    assign clearWrite = (state == hnmControlPkg::clearSweep);   // zero row write request
    assign clearRow = rowCount;
    assign ready = (state == hnmControlPkg::clearDone);         // requests taken only here

endmodule

`default_nettype wire

// File: rtl/readTracker.sv
`default_nettype none

module readTracker (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   ready,
    input  logic                   setHit,
    input  logic                   querySsid,
    input  logic                   queryRow,
    input  hnmGeometryPkg::ssidT   ssidIn,
    input  hnmGeometryPkg::rowIdxT rowIn,
    output hnmGeometryPkg::rowIdxT ramReadRow,
    output hnmControlPkg::reqKindE retKind,
    output hnmGeometryPkg::rowIdxT retRow,
    output hnmGeometryPkg::colIdxT retCol
);

    hnmControlPkg::reqKindE acceptKind;             // request picked this cycle
    hnmGeometryPkg::rowIdxT acceptRow;
    hnmGeometryPkg::colIdxT acceptCol;

    hnmControlPkg::reqKindE issueKind;              // tag alongside ramReadRow
    hnmGeometryPkg::colIdxT issueCol;

    // tag stages matching the memory read latency
    hnmControlPkg::reqKindE kindPipe [hnmGeometryPkg::ramReadLatency];
    hnmGeometryPkg::rowIdxT rowPipe [hnmGeometryPkg::ramReadLatency];
    hnmGeometryPkg::colIdxT colPipe [hnmGeometryPkg::ramReadLatency];

    // fixed priority, one request per cycle
    always_comb begin
        acceptKind = hnmControlPkg::reqNone;
        if (ready) begin
            if (setHit) begin
                acceptKind = hnmControlPkg::reqSetHit;
            end else if (querySsid) begin
                acceptKind = hnmControlPkg::reqQueryBit;
            end else if (queryRow) begin
                acceptKind = hnmControlPkg::reqQueryRow;
            end
        end
    end

    // split ssid into row and column
    assign acceptRow = (setHit || querySsid) ?
        ssidIn[hnmGeometryPkg::ssidBits-1:hnmGeometryPkg::colBits] : rowIn;
    assign acceptCol = ssidIn[hnmGeometryPkg::colBits-1:0];   // unused by row queries

    always_ff @(posedge clk) begin
        if (reset) begin
            issueKind <= hnmControlPkg::reqNone;                // drop anything in flight
            for (int i = 0; i < hnmGeometryPkg::ramReadLatency; i++) begin
                kindPipe[i] <= hnmControlPkg::reqNone;
            end
        end else begin
            issueKind <= acceptKind;
            kindPipe[0] <= issueKind;
            for (int i = 1; i < hnmGeometryPkg::ramReadLatency; i++) begin
                kindPipe[i] <= kindPipe[i-1];
            end
        end
    end

    // address and tag payload
    always_ff @(posedge clk) begin
        ramReadRow <= acceptRow;                                // read issued on accept edge
        issueCol <= acceptCol;
        rowPipe[0] <= ramReadRow;
        colPipe[0] <= issueCol;
        for (int i = 1; i < hnmGeometryPkg::ramReadLatency; i++) begin
            rowPipe[i] <= rowPipe[i-1];
            colPipe[i] <= colPipe[i-1];
        end
    end

    assign retKind = kindPipe[hnmGeometryPkg::ramReadLatency-1];  // aligned with ramReadData
    assign retRow = rowPipe[hnmGeometryPkg::ramReadLatency-1];
    assign retCol = colPipe[hnmGeometryPkg::ramReadLatency-1];

endmodule

`default_nettype wire

// File: rtl/hitMerger.sv
`default_nettype none

module hitMerger (
    input  logic                    clk,
    input  logic                    reset,
    input  hnmControlPkg::reqKindE  retKind,
    input  hnmGeometryPkg::rowIdxT  retRow,
    input  hnmGeometryPkg::colIdxT  retCol,
    input  hnmGeometryPkg::rowDataT ramReadData,
    input  logic                    clearWrite,
    input  hnmGeometryPkg::rowIdxT  clearRow,
    output logic                    ramWrite,
    output hnmGeometryPkg::rowIdxT  ramWriteRow,
    output hnmGeometryPkg::rowDataT ramWriteData,
    output logic                    bitValid,
    output hnmGeometryPkg::ssidT    bitSsid,
    output logic                    bitValue,
    output logic                    rowValid,
    output hnmGeometryPkg::rowIdxT  rowIndex,
    output hnmGeometryPkg::rowDataT rowData
);

    hnmGeometryPkg::rowDataT correctedRow;      // memory data with recent writes applied
    hnmGeometryPkg::rowDataT mergedRow;         // corrected row plus the new hit
    logic                    doWrite;
    hnmGeometryPkg::rowIdxT  nextWriteRow;
    hnmGeometryPkg::rowDataT nextWriteData;

    // bypass window, entry 0 is the newest write
    logic [hnmGeometryPkg::bypassDepth-1:0] winValid;
    hnmGeometryPkg::rowIdxT  winRow [hnmGeometryPkg::bypassDepth];
    hnmGeometryPkg::rowDataT winData [hnmGeometryPkg::bypassDepth];

    always_comb begin
        correctedRow = ramReadData;
        for (int i = hnmGeometryPkg::bypassDepth - 1; i >= 0; i--) begin
            if (winValid[i] && (winRow[i] == retRow)) begin
                correctedRow = winData[i];      // oldest first so the newest match wins
            end
        end
    end

    assign mergedRow = correctedRow | (hnmGeometryPkg::rowDataT'(1) << retCol);
    assign doWrite = clearWrite || (retKind == hnmControlPkg::reqSetHit);
    assign nextWriteRow = clearWrite ? clearRow : retRow;     // clear owns the port in sweep
    assign nextWriteData = clearWrite ? '0 : mergedRow;

    always_ff @(posedge clk) begin
        if (reset) begin
            ramWrite <= 1'b0;
            bitValid <= 1'b0;
            rowValid <= 1'b0;
            winValid <= '0;                                     // window forgotten
        end else begin
            ramWrite <= doWrite;
            bitValid <= (retKind == hnmControlPkg::reqQueryBit); // single cycle pulse
            rowValid <= (retKind == hnmControlPkg::reqQueryRow);
            if (doWrite) begin
                winValid <= {winValid[hnmGeometryPkg::bypassDepth-2:0], 1'b1};
            end
        end
    end

    always_ff @(posedge clk) begin
        ramWriteRow <= nextWriteRow;
        ramWriteData <= nextWriteData;
        bitSsid <= {retRow, retCol};                            // echo the queried ssid
        bitValue <= correctedRow[retCol];
        rowIndex <= retRow;
        rowData <= correctedRow;
        if (doWrite) begin
            winRow[0] <= nextWriteRow;                          // record every memory write
            winData[0] <= nextWriteData;
            for (int i = 1; i < hnmGeometryPkg::bypassDepth; i++) begin
                winRow[i] <= winRow[i-1];
                winData[i] <= winData[i-1];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/hitMapTop.sv
`default_nettype none

module hitMapTop (
    input  logic                    clk,
    input  logic                    reset,
    input  logic                    setHit,
    input  logic                    querySsid,
    input  logic                    queryRow,
    input  hnmGeometryPkg::ssidT    ssidIn,
    input  hnmGeometryPkg::rowIdxT  rowIn,
    output logic                    ready,
    output logic                    bitValid,
    output hnmGeometryPkg::ssidT    bitSsid,
    output logic                    bitValue,
    output logic                    rowValid,
    output hnmGeometryPkg::rowIdxT  rowIndex,
    output hnmGeometryPkg::rowDataT rowData
);

    logic                    clearWrite;        // zero sweep request
    hnmGeometryPkg::rowIdxT  clearRow;
    hnmGeometryPkg::rowIdxT  ramReadRow;
    hnmGeometryPkg::rowDataT ramReadData;
    hnmControlPkg::reqKindE  retKind;           // tag leaving the pipeline
    hnmGeometryPkg::rowIdxT  retRow;
    hnmGeometryPkg::colIdxT  retCol;
    logic                    ramWrite;          // from the single writer
    hnmGeometryPkg::rowIdxT  ramWriteRow;
    hnmGeometryPkg::rowDataT ramWriteData;

    clearSequencer clearSeq (
        .clk        (clk),
        .reset      (reset),
        .ready      (ready),
        .clearWrite (clearWrite),
        .clearRow   (clearRow)
    );

    readTracker tracker (
        .clk        (clk),
        .reset      (reset),
        .ready      (ready),
        .setHit     (setHit),
        .querySsid  (querySsid),
        .queryRow   (queryRow),
        .ssidIn     (ssidIn),
        .rowIn      (rowIn),
        .ramReadRow (ramReadRow),
        .retKind    (retKind),
        .retRow     (retRow),
        .retCol     (retCol)
    );

    ssidMapRam mapRam (
        .clk         (clk),
        .writeEnable (ramWrite),
        .writeRow    (ramWriteRow),
        .writeData   (ramWriteData),
        .readRow     (ramReadRow),
        .readData    (ramReadData)
    );

    hitMerger merger (
        .clk          (clk),
        .reset        (reset),
        .retKind      (retKind),
        .retRow       (retRow),
        .retCol       (retCol),
        .ramReadData  (ramReadData),
        .clearWrite   (clearWrite),
        .clearRow     (clearRow),
        .ramWrite     (ramWrite),
        .ramWriteRow  (ramWriteRow),
        .ramWriteData (ramWriteData),
        .bitValid     (bitValid),
        .bitSsid      (bitSsid),
        .bitValue     (bitValue),
        .rowValid     (rowValid),
        .rowIndex     (rowIndex),
        .rowData      (rowData)
    );

endmodule

`default_nettype wire

// File: tests/hitMapTb.sv
`default_nettype none

module hitMapTb;

    localparam int stages = hnmGeometryPkg::ramReadLatency + 2;     // accept edge to result edge
    localparam int lastStage = stages - 1;
    localparam int clearLimit = hnmGeometryPkg::nRows + hnmControlPkg::clearSettleCycles + 2;
    localparam int resetCycles = 8;
    localparam int randomCycles = 300;
    localparam int budgetCycles = 2 * (3 * (resetCycles + clearLimit + hnmGeometryPkg::nRows)
                                       + 2 * randomCycles + 40);    // every phase, doubled

    logic clk, reset;
    logic setHit, querySsid, queryRow;
    hnmGeometryPkg::ssidT ssidIn, bitSsid;
    hnmGeometryPkg::rowIdxT rowIn, rowIndex;
    hnmGeometryPkg::rowDataT rowData;
    logic ready, bitValid, bitValue, rowValid;

    int seed = 32'he843;
    int valueErrors = 0;
    int protocolErrors = 0;
    int waitCount = 0;                  // edges since reset fell with ready still low
    logic prevReset = 1'b0;             // reset level at the previous edge

    hnmGeometryPkg::rowDataT refMap [hnmGeometryPkg::nRows];     // expected map contents
    // expected results, slot i holds what was accepted i+1 edges ago
    logic                    expBitValid [stages];
    hnmGeometryPkg::ssidT    expSsid [stages];
    logic                    expBit [stages];
    logic                    expRowValid [stages];
    hnmGeometryPkg::rowIdxT  expRowIdx [stages];
    hnmGeometryPkg::rowDataT expRowData [stages];

    hitMapTop dut (.*);

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reference model of accepted requests
    always @(posedge clk) begin
        hnmGeometryPkg::rowIdxT inRow;
        hnmGeometryPkg::colIdxT inCol;
        logic live;
        inRow = ssidIn[hnmGeometryPkg::ssidBits-1:hnmGeometryPkg::colBits];
        inCol = ssidIn[hnmGeometryPkg::colBits-1:0];
        live = ready && !reset;                                 // requests taken on this edge
        prevReset <= reset;
        for (int i = 1; i < stages; i++) begin
            expBitValid[i] <= expBitValid[i-1];
            expSsid[i] <= expSsid[i-1];
            expBit[i] <= expBit[i-1];
            expRowValid[i] <= expRowValid[i-1];
            expRowIdx[i] <= expRowIdx[i-1];
            expRowData[i] <= expRowData[i-1];
        end
        expBitValid[0] <= live && !setHit && querySsid;         // a hit outranks both queries
        expSsid[0] <= ssidIn;
        expBit[0] <= refMap[inRow][inCol];
        expRowValid[0] <= live && !setHit && !querySsid && queryRow;
        expRowIdx[0] <= rowIn;
        expRowData[0] <= refMap[rowIn];
        if (reset) begin
            waitCount <= 0;
            foreach (refMap[i]) begin
                refMap[i] = '0;                                 // clear sweep empties the map
            end
            foreach (expBitValid[i]) begin
                expBitValid[i] <= 1'b0;                         // nothing pending survives
                expRowValid[i] <= 1'b0;
            end
        end else begin
            if (!ready) begin
                waitCount <= waitCount + 1;
            end
            if (live && setHit) begin
                refMap[inRow][inCol] = 1'b1;
            end
        end
    end

    assert property (@(posedge clk) prevReset |-> !ready && !bitValid && !rowValid)
        else reportProblem("ready or a result pulse was high right after a reset edge");
    assert property (@(posedge clk) disable iff (reset) ready || waitCount < clearLimit)
        else reportProblem("ready did not rise in time after reset");
    assert property (@(posedge clk) disable iff (reset) bitValid == expBitValid[lastStage])
        else reportProblem($sampled(bitValid) ? "unexpected bitValid pulse"
                                              : "missing bitValid pulse");
    assert property (@(posedge clk) disable iff (reset) rowValid == expRowValid[lastStage])
        else reportProblem($sampled(rowValid) ? "unexpected rowValid pulse"
                                              : "missing rowValid pulse");
    assert property (@(posedge clk) disable iff (reset) bitValid |-> bitSsid == expSsid[lastStage])
        else reportValue("bitSsid", $sampled(expSsid[lastStage]), $sampled(bitSsid));
    assert property (@(posedge clk) disable iff (reset) bitValid |-> bitValue == expBit[lastStage])
        else reportValue("bitValue", $sampled(expBit[lastStage]), $sampled(bitValue));
    assert property (@(posedge clk) disable iff (reset)
        rowValid |-> rowIndex == expRowIdx[lastStage])
        else reportValue("rowIndex", $sampled(expRowIdx[lastStage]), $sampled(rowIndex));
    assert property (@(posedge clk) disable iff (reset)
        rowValid |-> rowData == expRowData[lastStage])
        else reportValue("rowData", $sampled(expRowData[lastStage]), $sampled(rowData));

    task automatic reportValue(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        valueErrors++;
        $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
    endtask

    task automatic reportProblem(input string what);
        protocolErrors++;
        $display("t=%0t: %s", $time, what);
    endtask

    // one request cycle, driven on the falling edge
    task automatic driveRequest(input logic hit, input logic qBit, input logic qRow,
                                input hnmGeometryPkg::ssidT ssid,
                                input hnmGeometryPkg::rowIdxT row);
        @(negedge clk);
        setHit = hit;
        querySsid = qBit;
        queryRow = qRow;
        ssidIn = ssid;
        rowIn = row;
    endtask

    task automatic idleCycles(input int n);
        repeat (n) driveRequest(1'b0, 1'b0, 1'b0, '0, '0);
    endtask

    task automatic waitReady();
        idleCycles(1);
        while (ready !== 1'b1) begin
            idleCycles(1);                      // watchdog bounds this
        end
    endtask

    task automatic sweepRows();
        for (int r = 0; r < hnmGeometryPkg::nRows; r++) begin
            driveRequest(1'b0, 1'b0, 1'b1, '0, hnmGeometryPkg::rowIdxT'(r));
        end
        idleCycles(stages);
    endtask

    task automatic randomTraffic(input int n);
        logic [31:0] r;
        repeat (n) begin
            r = $random(seed);
            driveRequest(r[0] & r[1], r[2], r[3], r[10:4], r[14:11]);   // hits about 1 in 4
        end
    endtask

    initial begin
        reset = 1'b1;
        setHit = 1'b0;
        querySsid = 1'b0;
        queryRow = 1'b0;
        ssidIn = '0;
        rowIn = '0;
        repeat (resetCycles) @(negedge clk);
        reset = 1'b0;
        waitReady();
        sweepRows();                                        // fresh map reads back empty
        driveRequest(1'b1, 1'b0, 1'b0, {4'd5, 3'd3}, '0);
        driveRequest(1'b0, 1'b1, 1'b0, {4'd5, 3'd3}, '0);   // the hit itself
        driveRequest(1'b0, 1'b1, 1'b0, {4'd5, 3'd2}, '0);   // neighbours stay clear
        driveRequest(1'b0, 1'b1, 1'b0, {4'd5, 3'd4}, '0);
        driveRequest(1'b0, 1'b0, 1'b1, '0, 4'd5);
        // back to back hits on one row, row query right behind them
        driveRequest(1'b1, 1'b0, 1'b0, {4'd9, 3'd0}, '0);
        driveRequest(1'b1, 1'b0, 1'b0, {4'd9, 3'd2}, '0);
        driveRequest(1'b1, 1'b0, 1'b0, {4'd9, 3'd5}, '0);
        driveRequest(1'b1, 1'b0, 1'b0, {4'd9, 3'd7}, '0);
        driveRequest(1'b0, 1'b0, 1'b1, '0, 4'd9);
        idleCycles(stages);
        randomTraffic(randomCycles);
        idleCycles(stages);
        driveRequest(1'b1, 1'b1, 1'b0, {4'd12, 3'd1}, '0);  // query loses to the hit
        randomTraffic(6);
        reset = 1'b1;                                       // reset with reads in flight
        randomTraffic(resetCycles);
        reset = 1'b0;
        waitReady();
        sweepRows();
        idleCycles(stages);
        $display("value errors: %0d, protocol errors: %0d", valueErrors, protocolErrors);
        if (valueErrors + protocolErrors == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

    initial begin
        repeat (budgetCycles) @(posedge clk);
        $display("timeout: run still going after %0d cycles", budgetCycles);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

// File: sources.f
rtl/hnmGeometryPkg.sv
rtl/hnmControlPkg.sv
rtl/ssidMapRam.sv
rtl/clearSequencer.sv
rtl/readTracker.sv
rtl/hitMerger.sv
rtl/hitMapTop.sv
tests/hitMapTb.sv

// File: Bender.yml
package:
  name: hit_map

sources:
  - rtl/hnmGeometryPkg.sv
  - rtl/hnmControlPkg.sv
  - rtl/ssidMapRam.sv
  - rtl/clearSequencer.sv
  - rtl/readTracker.sv
  - rtl/hitMerger.sv
  - rtl/hitMapTop.sv
  - target: test
    files:
      - tests/hitMapTb.sv
